/* compile.f */
+incdir+include
source/video_pkg.sv
source/apb_pkg.sv
source/palette_bus_if.sv
source/apb_palette_fsm.sv
source/dither_phase_counter.sv
source/pixel_source_select.sv
source/palette_ram.sv
source/color_dither.sv
source/video_palette_top.sv
bench/video_palette_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the palette testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing \
	-f compile.f \
	--top-module video_palette_tb \
	-o video_palette_sim

# a $fatal in the testbench gives a nonzero exit status
./obj_dir/video_palette_sim

/* include/tb_video_model.svh */
// Colour pipeline reference model
`ifndef TB_VIDEO_MODEL_SVH
`define TB_VIDEO_MODEL_SVH

// 32-bit Fibonacci LFSR, taps 32 22 2 1
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
	return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
endfunction

// pulse pattern per fine level, bit n is the pulse at phase n
function automatic logic [7:0] dither_pattern_bits(input logic [2:0] fine);
	case (fine)
		3'd0: return 8'b00000000;
		3'd1: return 8'b00000001;
		3'd2: return 8'b01000001;
		3'd3: return 8'b01000101;
		3'd4: return 8'b10100101;
		3'd5: return 8'b10100111;
		3'd6: return 8'b11010111;
		default: return 8'b11011111;
	endcase
endfunction

// coarse level plus one pulse, never above 3
function automatic logic [1:0] channel_level(input logic [1:0] coarse, input logic [2:0] fine,
	input logic [2:0] phase);
	logic [7:0] pat;
	pat = dither_pattern_bits(fine);
	if (pat[phase] && coarse < 2'd3)
		return coarse + 2'd1;
	return coarse;
endfunction

// expected {red, green, blue} for one palette word
function automatic logic [5:0] expected_rgb(input logic [14:0] color, input logic blank,
	input logic [2:0] phase);
	logic [14:0] c;
	c = blank ? 15'd0 : color;
	return {channel_level(c[14:13], c[12:10], phase),
		channel_level(c[9:8], c[7:5], phase),
		channel_level(c[4:3], c[2:0], phase)};
endfunction

// palette index from the chosen source byte
function automatic logic [7:0] hires_index(input logic [7:0] src, input logic hires,
	input logic vga_on, input logic [1:0] nibble_sel);
	logic low;
	low = vga_on ? nibble_sel[0] : nibble_sel[1];
	if (!hires)
		return src;
	return {4'b1111, low ? src[3:0] : src[7:4]};
endfunction

// dither position from the mirrored counter and delayed line bit
function automatic logic [2:0] phase_of(input logic [2:0] count, input logic line_q,
	input logic vga_on);
	return vga_on ? {line_q, count[1:0]} : count;
endfunction

`endif

/* bench/video_palette_tb.sv */
// Palette video output testbench
`timescale 1ns/1ns
`default_nettype none

module video_palette_tb;

	`include "tb_video_model.svh"

	// cycle budget per test
	localparam int N_RW = 32;
	localparam int FILL_CYC = 256 * 4;
	localparam int RW_CYC = N_RW * 9 + 40;
	localparam int VIDEO_CYC = 400 + 400 + 200 + 128 + 16 * 4 + 40;
	localparam int CYCLE_LIMIT = (FILL_CYC + RW_CYC + VIDEO_CYC) * 3 / 2;

	logic clk;
	logic rst_n;
	logic psel, penable, pwrite;
	logic [9:0] paddr;
	logic [15:0] pwdata;
	logic [15:0] prdata;
	logic pready, pslverr;
	logic vga_on, vga_blank, tv_blank, vga_line, hires, tv_strobe;
	logic [1:0] nibble_sel;
	logic [7:0] tv_pixel, vga_pixel;
	logic [1:0] vred, vgrn, vblu;

	logic [31:0] lfsr_state = 32'h6b6df637;
	logic [14:0] pal [0:255];
	string test_name = "reset";
	int cycles = 0;

	// reference pipeline state
	logic check_en;
	logic [2:0] count_m;
	logic line_m;
	logic [7:0] tv_m;
	logic [2:0] ph_m;
	logic [7:0] src_m;
	logic [14:0] s1_color;
	logic s1_blank;
	logic s1_valid;
	logic exp_valid;
	logic [5:0] exp_rgb;

	video_palette_top UUT (
		.clk(clk), .rst_n(rst_n),
		.psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr), .pwdata(pwdata),
		.prdata(prdata), .pready(pready), .pslverr(pslverr),
		.vga_on(vga_on), .vga_blank(vga_blank), .tv_blank(tv_blank), .vga_line(vga_line),
		.hires(hires), .nibble_sel(nibble_sel), .tv_strobe(tv_strobe),
		.tv_pixel(tv_pixel), .vga_pixel(vga_pixel),
		.vred(vred), .vgrn(vgrn), .vblu(vblu)
	);

	always #4 clk = ~clk;

	// one LFSR step per bit taken
	function automatic logic [31:0] take_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++)
		begin
			lfsr_state = lfsr_next(lfsr_state);
			v = {v[30:0], lfsr_state[0]};
		end
		return v;
	endfunction

	task automatic check_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (expected !== actual)
		begin
			$display("CHECK FAILED %s expected %0h actual %0h", name, expected, actual);
			$display("TEST FAILED");
			$fatal(1, "mismatch");
		end
	endtask

	always @(posedge clk)
	begin
		cycles++;
		if (cycles >= CYCLE_LIMIT)
		begin
			$display("run did not finish within %0d cycles", CYCLE_LIMIT);
			$display("TEST FAILED");
			$fatal(1, "timeout");
		end
	end

	// expected outputs two edges after the pre-edge inputs
	always @(posedge clk)
	begin
		if (!rst_n)
		begin
			count_m = '0;
			line_m = 1'b0;
			s1_valid = 1'b0;
			exp_valid = 1'b0;
		end
		else
		begin
			ph_m = phase_of(count_m, line_m, vga_on);
			exp_valid = s1_valid;
			exp_rgb = expected_rgb(s1_color, s1_blank, ph_m);
			src_m = vga_on ? vga_pixel : tv_m;
			s1_color = pal[hires_index(src_m, hires, vga_on, nibble_sel)];
			s1_blank = vga_on ? vga_blank : tv_blank;
			s1_valid = check_en;
			count_m = count_m + 3'd1;
			line_m = vga_line;
			if (tv_strobe)
				tv_m = tv_pixel;
		end
	end

	always @(negedge clk)
	begin
		if (rst_n && exp_valid)
			check_value(test_name, {26'd0, exp_rgb}, {26'd0, vred, vgrn, vblu});
	end

	task automatic apb_write(input logic [9:0] addr, input logic [15:0] data,
		output int waits, output logic err);
		@(posedge clk);
		psel <= 1'b1;
		penable <= 1'b0;
		pwrite <= 1'b1;
		paddr <= addr;
		pwdata <= data;
		@(posedge clk);
		penable <= 1'b1;
		waits = 0;
		@(negedge clk);
		while (!pready)
		begin
			waits++;
			@(negedge clk);
		end
		err = pslverr;
		if (!err)
			pal[addr[9:2]] = data[14:0];
		@(posedge clk);
		psel <= 1'b0;
		penable <= 1'b0;
	endtask

	task automatic apb_read(input logic [9:0] addr, output logic [15:0] data,
		output int waits, output logic err);
		@(posedge clk);
		psel <= 1'b1;
		penable <= 1'b0;
		pwrite <= 1'b0;
		paddr <= addr;
		@(posedge clk);
		penable <= 1'b1;
		waits = 0;
		@(negedge clk);
		while (!pready)
		begin
			waits++;
			@(negedge clk);
		end
		err = pslverr;
		data = prdata;
		@(posedge clk);
		psel <= 1'b0;
		penable <= 1'b0;
	endtask

	// n cycles of random pixels in mode 0 vga, 1 tv or 2 mixed with blanking
	task automatic drive_video(input int n, input int mode);
		logic on;
		for (int i = 0; i < n; i++)
		begin
			@(posedge clk);
			on = (mode == 0) ? 1'b1 : (mode == 1) ? 1'b0 : take_bits(1) != 0;
			check_en <= 1'b1;
			vga_on <= on;
			vga_pixel <= 8'(take_bits(8));
			tv_pixel <= 8'(take_bits(8));
			tv_strobe <= take_bits(2) == 0;
			hires <= (mode == 0) ? 1'b0 : take_bits(1) != 0;
			nibble_sel <= 2'(take_bits(2));
			if (i % 8 == 0)
				vga_line <= take_bits(1) != 0;
			vga_blank <= (mode == 2) ? take_bits(2) == 0 : 1'b0;
			tv_blank <= (mode == 2) ? take_bits(2) == 0 : 1'b0;
		end
		@(posedge clk);
		check_en <= 1'b0;
	endtask

	initial
	begin
		logic [15:0] rd;
		logic [15:0] wd;
		logic [7:0] entry;
		logic err;
		int waits;
		clk = 1'b0;
		rst_n = 1'b0;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = '0;
		pwdata = '0;
		vga_on = 1'b1;
		vga_blank = 1'b0;
		tv_blank = 1'b0;
		vga_line = 1'b0;
		hires = 1'b0;
		nibble_sel = '0;
		tv_strobe = 1'b0;
		tv_pixel = '0;
		vga_pixel = '0;
		check_en = 1'b0;
		repeat (4) @(posedge clk);
		rst_n <= 1'b1;
		@(negedge clk);
		check_value("reset colour", 0, {26'd0, vred, vgrn, vblu});
		check_value("reset pready", 0, {31'd0, pready});
		check_value("reset pslverr", 0, {31'd0, pslverr});

		test_name = "palette fill";
		for (int i = 0; i < 256; i++)
		begin
			apb_write({8'(i), 2'b00}, 16'(take_bits(16)), waits, err);
			check_value("fill write waits", 0, waits);
			check_value("fill write error", 0, {31'd0, err});
		end

		for (int i = 0; i < N_RW; i++)
		begin
			entry = 8'(take_bits(8));
			wd = 16'(take_bits(16));
			apb_write({entry, 2'b00}, wd, waits, err);
			check_value("write waits", 0, waits);
			apb_read({entry, 2'b00}, rd, waits, err);
			check_value("read waits", 1, waits);
			check_value("read error", 0, {31'd0, err});
			check_value("read data", {17'd0, wd[14:0]}, {16'd0, rd});
		end

		// misaligned accesses leave the entry alone
		entry = 8'h42;
		apb_write({entry, 2'b01}, 16'h7fff ^ {1'b0, pal[entry]}, waits, err);
		check_value("misaligned write error", 1, {31'd0, err});
		check_value("misaligned write waits", 0, waits);
		apb_read({entry, 2'b10}, rd, waits, err);
		check_value("misaligned read error", 1, {31'd0, err});
		check_value("misaligned read waits", 0, waits);
		check_value("misaligned read data", 0, {16'd0, rd});
		apb_read({entry, 2'b00}, rd, waits, err);
		check_value("entry after misaligned write", {17'd0, pal[entry]}, {16'd0, rd});

		test_name = "vga path";
		drive_video(400, 0);

		// tv byte must be latched once before it is used
		@(posedge clk);
		tv_strobe <= 1'b1;
		tv_pixel <= 8'h5a;
		test_name = "tv path";
		drive_video(400, 1);
		test_name = "blanking";
		drive_video(200, 2);

		// saturation and fine level edges
		for (int i = 0; i < 8; i++)
		begin
			wd = {1'b0, 2'd3, 3'(i), 2'd3, 3'(i), 2'd3, 3'(i)};
			apb_write({8'h10 + 8'(i), 2'b00}, wd, waits, err);
			wd = {1'b0, 2'd0, 3'(i), 2'd1, 3'(i), 2'd2, 3'(i)};
			apb_write({8'h18 + 8'(i), 2'b00}, wd, waits, err);
		end
		test_name = "saturation";
		// each entry held for eight cycles to meet every phase
		for (int i = 0; i < 128; i++)
		begin
			@(posedge clk);
			check_en <= 1'b1;
			vga_on <= 1'b0;
			hires <= 1'b0;
			tv_blank <= 1'b0;
			tv_strobe <= 1'b1;
			tv_pixel <= 8'h10 + 8'(i / 8);
		end
		@(posedge clk);
		check_en <= 1'b0;
		repeat (3) @(posedge clk);

		$display("TEST PASSED");
		$finish;
	end

endmodule

`default_nettype wire

/* source/video_palette_top.sv */
// Palette video output stage
`timescale 1ns/1ns
`default_nettype none

module video_palette_top (
	input  wire logic                       clk,
	input  wire logic                       rst_n,

	// cpu bus
	input  wire logic                       psel,
	input  wire logic                       penable,
	input  wire logic                       pwrite,
	input  wire logic [apb_pkg::ADDR_W-1:0] paddr,
	input  wire logic [apb_pkg::DATA_W-1:0] pwdata,
	output      logic [apb_pkg::DATA_W-1:0] prdata,
	output      logic                       pready,
	output      logic                       pslverr,

	// video controls
	input  wire logic                       vga_on,
	input  wire logic                       vga_blank,
	input  wire logic                       tv_blank,
	input  wire logic                       vga_line,
	input  wire logic                       hires,
	input  wire logic [1:0]                 nibble_sel,
	input  wire logic                       tv_strobe,

	// pixel sources
	input  wire logic [7:0]                 tv_pixel,
	input  wire logic [7:0]                 vga_pixel,

	// resistor DAC
	output      logic [1:0]                 vred,
	output      logic [1:0]                 vgrn,
	output      logic [1:0]                 vblu
);

	logic [video_pkg::INDEX_W-1:0] index;
	logic                          blank_aligned;
	logic [video_pkg::PHASE_W-1:0] phase;
	video_pkg::color_t             pixel_color;

	palette_bus_if bus_if ();

	apb_palette_fsm u_apb (
		.clk     (clk),
		.rst_n   (rst_n),
		.psel    (psel),
		.penable (penable),
		.pwrite  (pwrite),
		.paddr   (paddr),
		.pwdata  (pwdata),
		.prdata  (prdata),
		.pready  (pready),
		.pslverr (pslverr),
		.bus     (bus_if.cpu)
	);

	dither_phase_counter u_phase (
		.clk      (clk),
		.rst_n    (rst_n),
		.vga_on   (vga_on),
		.vga_line (vga_line),
		.phase    (phase)
	);

	pixel_source_select u_source (
		.clk           (clk),
		.rst_n         (rst_n),
		.vga_on        (vga_on),
		.tv_strobe     (tv_strobe),
		.hires         (hires),
		.nibble_sel    (nibble_sel),
		.vga_blank     (vga_blank),
		.tv_blank      (tv_blank),
		.tv_pixel      (tv_pixel),
		.vga_pixel     (vga_pixel),
		.index         (index),
		.blank_aligned (blank_aligned)
	);

	palette_ram u_ram (
		.clk         (clk),
		.index       (index),
		.pixel_color (pixel_color),
		.bus         (bus_if.ram)
	);

	color_dither u_dither (
		.clk           (clk),
		.rst_n         (rst_n),
		.pixel_color   (pixel_color),
		.blank_aligned (blank_aligned),
		.phase         (phase),
		.vred          (vred),
		.vgrn          (vgrn),
		.vblu          (vblu)
	);

endmodule

`default_nettype wire

/* source/color_dither.sv */
// Colour dither and DAC output
`timescale 1ns/1ns
`default_nettype none

module color_dither (
	input  wire logic                          clk,
	input  wire logic                          rst_n,
	input  wire video_pkg::color_t             pixel_color,
	input  wire logic                          blank_aligned,
	input  wire logic [video_pkg::PHASE_W-1:0] phase,
	output      logic [1:0]                    vred,
	output      logic [1:0]                    vgrn,
	output      logic [1:0]                    vblu
);

	video_pkg::color_t color;
	logic [1:0]        red_next;
	logic [1:0]        grn_next;
	logic [1:0]        blu_next;

	// one coarse step where the pattern has a pulse, saturating at 3
	function automatic logic [1:0] dither_step(
		input logic [1:0]                    coarse,
		input logic [2:0]                    fine,
		input logic [video_pkg::PHASE_W-1:0] ph
	);
		logic pulse;
		pulse = video_pkg::DITHER_PATTERN[fine][ph];
		if (pulse && (coarse != 2'b11))
			return coarse + 2'b01;
		return coarse;
	endfunction

	// blanked pixels are black
	assign color = blank_aligned ? '0 : pixel_color;

	assign red_next = dither_step(color.red_coarse, color.red_fine, phase);
	assign grn_next = dither_step(color.grn_coarse, color.grn_fine, phase);
	assign blu_next = dither_step(color.blu_coarse, color.blu_fine, phase);

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			vred <= 2'b00;
			vgrn <= 2'b00;
			vblu <= 2'b00;
		end
		else
		begin
			vred <= red_next;
			vgrn <= grn_next;
			vblu <= blu_next;
		end
	end

endmodule

`default_nettype wire

/* source/palette_ram.sv */
// Colour RAM
`timescale 1ns/1ns
`default_nettype none

module palette_ram (
	input  wire logic                          clk,
	input  wire logic [video_pkg::INDEX_W-1:0] index,
	output      video_pkg::color_t             pixel_color,
	palette_bus_if.ram                         bus
);

	localparam int DEPTH = 1 << video_pkg::INDEX_W;

	logic [video_pkg::COLOR_W-1:0] mem [0:DEPTH-1];

	// video port, reads the old word on a same cycle write
	always_ff @(posedge clk)
	begin
		pixel_color <= video_pkg::color_t'(mem[index]);
	end

	// cpu port
	always_ff @(posedge clk)
	begin
		if (bus.we)
			mem[bus.addr] <= bus.wdata;
		if (bus.re)
			bus.rdata <= video_pkg::color_t'(mem[bus.addr]);
	end

endmodule

`default_nettype wire

/* source/pixel_source_select.sv */
// Pixel source selection
`timescale 1ns/1ns
`default_nettype none

module pixel_source_select (
	input  wire logic                          clk,
	input  wire logic                          rst_n,
	input  wire logic                          vga_on,
	input  wire logic                          tv_strobe,
	input  wire logic                          hires,
	input  wire logic [1:0]                    nibble_sel,
	input  wire logic                          vga_blank,
	input  wire logic                          tv_blank,
	input  wire logic [7:0]                    tv_pixel,
	input  wire logic [7:0]                    vga_pixel,
	output      logic [video_pkg::INDEX_W-1:0] index,
	output      logic                          blank_aligned
);

	logic [7:0] tv_q;
	logic [7:0] src_byte;
	logic       low_nibble;
	logic       blank;

	// tv byte held between strobes
	always_ff @(posedge clk)
	begin
		if (tv_strobe)
			tv_q <= tv_pixel;
	end

	assign src_byte   = vga_on ? vga_pixel : tv_q;
	assign low_nibble = vga_on ? nibble_sel[0] : nibble_sel[1];
	assign blank      = vga_on ? vga_blank : tv_blank;

	// hires uses the top 16 palette entries
	assign index = hires ? {4'b1111, low_nibble ? src_byte[3:0] : src_byte[7:4]} : src_byte;

	// blank follows the ram read latency
	always_ff @(posedge clk)
	begin
		if (!rst_n)
			blank_aligned <= 1'b1;
		else
			blank_aligned <= blank;
	end

endmodule

`default_nettype wire

/* source/dither_phase_counter.sv */
// Dither phase counter
`timescale 1ns/1ns
`default_nettype none

module dither_phase_counter (
	input  wire logic                          clk,
	input  wire logic                          rst_n,
	input  wire logic                          vga_on,
	input  wire logic                          vga_line,
	output      logic [video_pkg::PHASE_W-1:0] phase
);

	logic [video_pkg::PHASE_W-1:0] count;
	logic                          line_q;

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			count  <= '0;
			line_q <= 1'b0;
		end
		else
		begin
			count  <= count + 1'b1;
			line_q <= vga_line;
		end
	end

	// vga swaps patterns between odd and even lines, tv walks all eight steps
	assign phase = vga_on ? {line_q, count[video_pkg::PHASE_W-2:0]} : count;

endmodule

`default_nettype wire

/* source/apb_palette_fsm.sv */
// APB palette slave
`timescale 1ns/1ns
`default_nettype none

module apb_palette_fsm (
	input  wire logic                       clk,
	input  wire logic                       rst_n,
	input  wire logic                       psel,
	input  wire logic                       penable,
	input  wire logic                       pwrite,
	input  wire logic [apb_pkg::ADDR_W-1:0] paddr,
	input  wire logic [apb_pkg::DATA_W-1:0] pwdata,
	output      logic [apb_pkg::DATA_W-1:0] prdata,
	output      logic                       pready,
	output      logic                       pslverr,
	palette_bus_if.cpu                      bus
);

	localparam int PAD_W = apb_pkg::DATA_W - video_pkg::COLOR_W;

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_ACCESS,
		ST_RD_WAIT,
		ST_DONE
	} state_t;

	state_t state;
	logic   setup;
	logic   misaligned;

	// setup phase of a new transfer
	assign setup = (state == ST_IDLE) && psel && !penable;
	assign misaligned = |paddr[apb_pkg::ALIGN_HI:0];

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			state   <= ST_IDLE;
			pready  <= 1'b0;
			pslverr <= 1'b0;
			bus.we  <= 1'b0;
			bus.re  <= 1'b0;
		end
		else
		begin
			// strobes and handshake last one cycle
			bus.we  <= 1'b0;
			bus.re  <= 1'b0;
			pready  <= 1'b0;
			pslverr <= 1'b0;
			case (state)
				ST_IDLE:
					if (setup)
					begin
						if (misaligned)
						begin
							state   <= ST_ACCESS;
							pready  <= 1'b1;
							pslverr <= 1'b1;
						end
						else if (pwrite)
						begin
							state  <= ST_ACCESS;
							pready <= 1'b1;
							bus.we <= 1'b1;
						end
						else
						begin
							state  <= ST_RD_WAIT;
							bus.re <= 1'b1;
						end
					end
				// ram read in flight, answer next cycle
				ST_RD_WAIT:
				begin
					state  <= ST_DONE;
					pready <= 1'b1;
				end
				ST_ACCESS,
				ST_DONE:
					state <= ST_IDLE;
				default:
					state <= ST_IDLE;
			endcase
		end
	end

	// address and data captured in the setup cycle
	always_ff @(posedge clk)
	begin
		if (setup)
		begin
			bus.addr  <= paddr[apb_pkg::ENTRY_HI:apb_pkg::ENTRY_LO];
			// top data bit has no storage
			bus.wdata <= video_pkg::color_t'(pwdata[video_pkg::COLOR_W-1:0]);
		end
	end

	assign prdata = (state == ST_DONE) ? {{PAD_W{1'b0}}, bus.rdata} : '0;

endmodule

`default_nettype wire

/* source/palette_bus_if.sv */
// CPU side colour RAM access
`timescale 1ns/1ns
`default_nettype none

interface palette_bus_if;

	logic                          we;
	logic                          re;
	logic [video_pkg::INDEX_W-1:0] addr;
	video_pkg::color_t             wdata;
	// valid one clock after re
	video_pkg::color_t             rdata;

	modport cpu (
		output we, re, addr, wdata,
		input  rdata
	);

	modport ram (
		input  we, re, addr, wdata,
		output rdata
	);

endinterface

`default_nettype wire

/* source/apb_pkg.sv */
// APB bus constants
`default_nettype none

package apb_pkg;

	// bus widths
	localparam int ADDR_W = 10;
	localparam int DATA_W = 16;

	// one palette entry per 32-bit word slot
	localparam int ENTRY_HI = 9;
	localparam int ENTRY_LO = 2;

	// low address bits that must be zero
	localparam int ALIGN_HI = 1;

endpackage

`default_nettype wire

/* source/video_pkg.sv */
// Colour format definitions
`default_nettype none

package video_pkg;

	// palette index and colour word sizes
	localparam int INDEX_W = 8;
	localparam int COLOR_W = 15;

	// dither position, eight steps
	localparam int PHASE_W = 3;

	// one 5-bit channel is a coarse DAC level plus a fine level
	typedef struct packed {
		logic [1:0] red_coarse;
		logic [2:0] red_fine;
		logic [1:0] grn_coarse;
		logic [2:0] grn_fine;
		logic [1:0] blu_coarse;
		logic [2:0] blu_fine;
	} color_t;

	// pulse patterns per fine level, bit n is the step at phase n
	// the number of ones grows with the fine level
	localparam logic [(1 << PHASE_W) - 1:0] DITHER_PATTERN [0:7] = '{
		8'b00000000,
		8'b00000001,
		8'b01000001,
		8'b01000101,
		8'b10100101,
		8'b10100111,
		8'b11010111,
		8'b11011111
	};

endpackage

`default_nettype wire
